//--- logic/arrayAllocator.sv
// Array allocator
// Tracks live arrays, a LIFO of freed array numbers and the count handed out,
// and serves Alloc, Free and Reset
`timescale 1ns/1ps
`include "heap_params.svh"

module arrayAllocator (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cmdValid,
  input  heapPkg::heapAction_t  cmdAction,
  input  heapPkg::arrayId_t     cmdArray,
  output logic                  arrayLive,             // Live flag of cmdArray
  output heapPkg::arrayId_t     freshArray,            // Array granted by Alloc
  output logic                  freshValid,
  output logic                  allocHit,              // Command belongs here
  output heapPkg::element_t     allocResult,
  output heapPkg::errorCode_t   allocError
);
  import heapPkg::*;

  typedef logic [`HEAP_ADDRESS_BITS:0] stackPointer_t;  // 0 to ARRAYS entries

  logic [`HEAP_ARRAYS-1:0] liveFlags;
  arrayId_t                freeStack [`HEAP_ARRAYS];   // Freed arrays with the latest on top
  stackPointer_t           freeTop;                    // Entries on the stack
  stackPointer_t           topBelow;                   // Slot of the top entry
  arrayId_t                allocCount;                 // New arrays handed out
  logic                    stackPush;
  logic                    clearAll;                   // Reset action

  assign arrayLive = liveFlags[cmdArray];
  assign topBelow  = freeTop - stackPointer_t'(1);
  assign clearAll  = cmdValid && (cmdAction == actReset);

  // ------------------------------
  // Command response
  always_comb begin
    freshArray  = allocCount;                          // Next new array by default
    freshValid  = 1'b0;
    allocHit    = 1'b0;
    allocResult = '0;
    allocError  = '0;
    stackPush   = 1'b0;
    if (cmdValid) begin
      case (cmdAction)
        actReset: allocHit = 1'b1;
        actAlloc: begin
          allocHit = 1'b1;
          if (freeTop != '0) begin                     // Reuse latest freed
            freshArray = freeStack[topBelow[`HEAP_ADDRESS_BITS-1:0]];
            freshValid = 1'b1;
          end else if (allocCount < arrayId_t'(`HEAP_ARRAYS - 1)) begin
            freshValid = 1'b1;
          end else begin
            allocError = `HEAP_ERR_OUT_OF_MEMORY;
          end
          allocResult = element_t'(freshArray);
        end
        actFree: begin
          allocHit = 1'b1;
          if (arrayLive) stackPush = 1'b1;
          else           allocError = `HEAP_ERR_FREE + `HEAP_ERR_NOT_LIVE;
        end
        default: ;                                     // Store commands
      endcase
    end
  end

  // ------------------------------
  // State update
  always_ff @(posedge clock) begin
    if (reset || clearAll) begin
      liveFlags  <= '0;
      freeTop    <= '0;
      allocCount <= '0;
    end else if (freshValid) begin
      liveFlags[freshArray] <= 1'b1;
      if (freeTop != '0) freeTop    <= topBelow;       // Pop the stack
      else               allocCount <= allocCount + arrayId_t'(1);
    end else if (stackPush) begin
      liveFlags[cmdArray] <= 1'b0;
      freeTop             <= freeTop + stackPointer_t'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (stackPush) freeStack[freeTop[`HEAP_ADDRESS_BITS-1:0]] <= cmdArray;
  end

  stackBound: assert property (@(posedge clock) disable iff (reset)
    freeTop <= stackPointer_t'(`HEAP_ARRAYS));

  freshOnAlloc: assert property (@(posedge clock) disable iff (reset)
    freshValid |-> cmdValid && (cmdAction == actAlloc));

endmodule

//--- logic/arrayStore.sv
// Array store
// Element memory and per-array sizes, serving the element and stack commands
// with live and bounds checks
`timescale 1ns/1ps
`include "heap_params.svh"

module arrayStore (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    cmdValid,
  input  heapPkg::heapAction_t    cmdAction,
  input  heapPkg::arrayId_t       cmdArray,
  input  heapPkg::elementIndex_t  cmdIndex,
  input  heapPkg::element_t       cmdData,
  input  logic                    arrayLive,
  input  heapPkg::arrayId_t       freshArray,          // Array granted by Alloc
  input  logic                    freshValid,
  output heapPkg::element_t       storeResult,
  output heapPkg::errorCode_t     storeError
);
  import heapPkg::*;

  element_t      elements [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  arraySize_t    sizes    [`HEAP_ARRAYS];
  arraySize_t    currentSize;
  arraySize_t    indexSize;                            // Index widened to a size
  arraySize_t    lastSize;                             // Size after a pop
  arraySize_t    sizeNext;
  element_t      currentElement;
  element_t      sum;                                  // Wraps at element width
  element_t      writeValue;
  elementIndex_t writeIndex;
  logic          readable;
  logic          elementWrite;
  logic          sizeWrite;
  logic          clearSizes;

  assign currentSize    = sizes[cmdArray];
  assign indexSize      = {1'b0, cmdIndex};
  assign lastSize       = currentSize - arraySize_t'(1);
  assign currentElement = elements[cmdArray][cmdIndex];
  assign sum            = currentElement + cmdData;
  assign readable       = indexSize < currentSize;
  assign clearSizes     = cmdValid && (cmdAction == actReset);

  // ------------------------------
  // Command response
  always_comb begin
    storeResult  = '0;
    storeError   = '0;
    elementWrite = 1'b0;
    writeIndex   = cmdIndex;
    writeValue   = cmdData;
    sizeWrite    = 1'b0;
    sizeNext     = currentSize;
    if (cmdValid) begin
      case (cmdAction)
        actWrite: begin
          if (!arrayLive) storeError = `HEAP_ERR_WRITE + `HEAP_ERR_NOT_LIVE;
          else begin
            elementWrite = 1'b1;
            storeResult  = cmdData;
            if (!readable) begin                       // Grow to cover index
              sizeWrite = 1'b1;
              sizeNext  = indexSize + arraySize_t'(1);
            end
          end
        end
        actRead: begin
          if (!arrayLive)     storeError  = `HEAP_ERR_READ + `HEAP_ERR_NOT_LIVE;
          else if (!readable) storeError  = `HEAP_ERR_READ + `HEAP_ERR_BOUNDS;
          else                storeResult = currentElement;
        end
        actSize: begin
          if (!arrayLive) storeError  = `HEAP_ERR_SIZE + `HEAP_ERR_NOT_LIVE;
          else            storeResult = element_t'(currentSize);
        end
        actPush: begin
          if (!arrayLive) storeError = `HEAP_ERR_PUSH + `HEAP_ERR_NOT_LIVE;
          else if (currentSize >= arraySize_t'(`HEAP_ARRAY_LENGTH))
            storeError = `HEAP_ERR_PUSH + `HEAP_ERR_LIMIT;
          else begin
            elementWrite = 1'b1;                       // Append at the end
            writeIndex   = currentSize[`HEAP_INDEX_BITS-1:0];
            sizeWrite    = 1'b1;
            sizeNext     = currentSize + arraySize_t'(1);
          end
        end
        actPop: begin
          if (!arrayLive)              storeError = `HEAP_ERR_POP + `HEAP_ERR_NOT_LIVE;
          else if (currentSize == '0)  storeError = `HEAP_ERR_POP + `HEAP_ERR_LIMIT;
          else begin
            sizeWrite   = 1'b1;
            sizeNext    = lastSize;
            storeResult = elements[cmdArray][lastSize[`HEAP_INDEX_BITS-1:0]];
          end
        end
        actAdd, actAddAfter: begin
          if (!arrayLive) begin
            storeError = (cmdAction == actAdd) ? `HEAP_ERR_ADD : `HEAP_ERR_ADDAFTER;
            storeError = storeError + `HEAP_ERR_NOT_LIVE;
          end else if (!readable) begin
            storeError = (cmdAction == actAdd) ? `HEAP_ERR_ADD : `HEAP_ERR_ADDAFTER;
            storeError = storeError + `HEAP_ERR_BOUNDS;
          end else begin
            elementWrite = 1'b1;
            writeValue   = sum;
            storeResult  = (cmdAction == actAdd) ? sum : currentElement;
          end
        end
        default: ;                                     // Allocator commands
      endcase
    end
  end

  // ------------------------------
  // State update
  always_ff @(posedge clock) begin
    if (reset || clearSizes) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
    end else if (freshValid) begin
      sizes[freshArray] <= '0;                         // New array starts empty
    end else if (sizeWrite) begin
      sizes[cmdArray] <= sizeNext;
    end
  end

  always_ff @(posedge clock) begin
    if (elementWrite) elements[cmdArray][writeIndex] <= writeValue;
  end

  for (genvar g = 0; g < `HEAP_ARRAYS; g++) begin : sizeCheck
    sizeBound: assert property (@(posedge clock) disable iff (reset)
      sizes[g] <= arraySize_t'(`HEAP_ARRAY_LENGTH));
  end

endmodule

//--- logic/commandDecoder.sv
// Command decoder
// Registers each command strobe and flags action codes the heap does not know
`timescale 1ns/1ps
`include "heap_params.svh"

module commandDecoder (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [`HEAP_ACTION_BITS-1:0]  action,        // Zero means idle
  input  heapPkg::arrayId_t             array,
  input  heapPkg::elementIndex_t        index,
  input  heapPkg::element_t             data,
  output logic                          cmdValid,
  output heapPkg::heapAction_t          cmdAction,
  output heapPkg::arrayId_t             cmdArray,
  output heapPkg::elementIndex_t        cmdIndex,
  output heapPkg::element_t             cmdData,
  output logic                          cmdBadAction
);
  import heapPkg::*;

  logic knownAction;                                   // Code is one of the kept actions

  always_comb begin
    knownAction = 1'b0;
    case (heapAction_t'(action))
      actReset, actWrite, actRead, actSize, actPush,
      actPop, actAlloc, actFree, actAdd, actAddAfter: knownAction = 1'b1;
      default: knownAction = 1'b0;                     // Includes idle
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cmdValid     <= 1'b0;
      cmdAction    <= actIdle;
      cmdBadAction <= 1'b0;
    end else begin
      cmdValid     <= |action;                         // One cycle per strobe
      cmdAction    <= knownAction ? heapAction_t'(action) : actIdle;
      cmdBadAction <= (|action) && !knownAction;
    end
  end

  always_ff @(posedge clock) begin                     // Payload registers
    cmdArray <= array;
    cmdIndex <= index;
    cmdData  <= data;
  end

  badNeedsValid: assert property (@(posedge clock) disable iff (reset)
    cmdBadAction |-> cmdValid);

endmodule

//--- logic/heapMemory.sv
// Heap memory top level
// Decoder, allocator, store and response register in a two cycle pipeline
`timescale 1ns/1ps
`include "heap_params.svh"

module heapMemory (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [`HEAP_ACTION_BITS-1:0]  action,
  input  heapPkg::arrayId_t             array,
  input  heapPkg::elementIndex_t        index,
  input  heapPkg::element_t             data,
  output heapPkg::element_t             out,
  output heapPkg::errorCode_t           error,
  output logic                          done
);
  import heapPkg::*;

  // ------------------------------
  // Decoded command
  logic          cmdValid;
  heapAction_t   cmdAction;
  arrayId_t      cmdArray;
  elementIndex_t cmdIndex;
  element_t      cmdData;
  logic          cmdBadAction;

  // ------------------------------
  // Processing results
  logic          arrayLive;
  arrayId_t      freshArray;
  logic          freshValid;
  logic          allocHit;
  element_t      allocResult;
  errorCode_t    allocError;
  element_t      storeResult;
  errorCode_t    storeError;

  commandDecoder i_decoder (
    .clock(clock), .reset(reset),
    .action(action), .array(array), .index(index), .data(data),
    .cmdValid(cmdValid), .cmdAction(cmdAction), .cmdArray(cmdArray),
    .cmdIndex(cmdIndex), .cmdData(cmdData), .cmdBadAction(cmdBadAction)
  );

  arrayAllocator i_allocator (
    .clock(clock), .reset(reset),
    .cmdValid(cmdValid), .cmdAction(cmdAction), .cmdArray(cmdArray),
    .arrayLive(arrayLive), .freshArray(freshArray), .freshValid(freshValid),
    .allocHit(allocHit), .allocResult(allocResult), .allocError(allocError)
  );

  arrayStore i_store (
    .clock(clock), .reset(reset),
    .cmdValid(cmdValid), .cmdAction(cmdAction), .cmdArray(cmdArray),
    .cmdIndex(cmdIndex), .cmdData(cmdData), .arrayLive(arrayLive),
    .freshArray(freshArray), .freshValid(freshValid),
    .storeResult(storeResult), .storeError(storeError)
  );

  responseRegister i_response (
    .clock(clock), .reset(reset),
    .cmdValid(cmdValid), .cmdAction(cmdAction), .cmdBadAction(cmdBadAction),
    .allocHit(allocHit), .allocResult(allocResult), .allocError(allocError),
    .storeResult(storeResult), .storeError(storeError),
    .out(out), .error(error), .done(done)
  );

endmodule

//--- logic/heapPkg.sv
// Heap package
// Action enum and the width types used across the heap datapath
`include "heap_params.svh"

package heapPkg;

  // ------------------------------
  // Actions kept by this heap
  typedef enum logic [`HEAP_ACTION_BITS-1:0] {
    actIdle     = 8'd0,                                // No command
    actReset    = `HEAP_ACT_RESET,
    actWrite    = `HEAP_ACT_WRITE,
    actRead     = `HEAP_ACT_READ,
    actSize     = `HEAP_ACT_SIZE,
    actPush     = `HEAP_ACT_PUSH,
    actPop      = `HEAP_ACT_POP,
    actAlloc    = `HEAP_ACT_ALLOC,
    actFree     = `HEAP_ACT_FREE,
    actAdd      = `HEAP_ACT_ADD,
    actAddAfter = `HEAP_ACT_ADDAFTER
  } heapAction_t;

  // ------------------------------
  // Payload widths
  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayId_t;    // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]   elementIndex_t;
  typedef logic [`HEAP_INDEX_BITS:0]     arraySize_t;  // Holds 0 to ARRAY_LENGTH
  typedef logic [`HEAP_DATA_BITS-1:0]    element_t;
  typedef logic [`HEAP_ERROR_BITS-1:0]   errorCode_t;

endpackage

//--- logic/heap_params.svh
// Heap parameters
// Widths, action codes and error codes shared by the heap datapath
`ifndef HEAP_PARAMS_SVH
`define HEAP_PARAMS_SVH

// ------------------------------
// Widths
`define HEAP_ADDRESS_BITS 2                            // Array number bits
`define HEAP_INDEX_BITS   3                            // Element index bits
`define HEAP_DATA_BITS    12                           // Element width
`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)    // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)      // Elements per array
`define HEAP_ACTION_BITS  8                            // Action code width
`define HEAP_ERROR_BITS   32                           // Error code width

// ------------------------------
// Action codes
`define HEAP_ACT_RESET    8'd1                         // Empty the heap
`define HEAP_ACT_WRITE    8'd2
`define HEAP_ACT_READ     8'd3
`define HEAP_ACT_SIZE     8'd4
`define HEAP_ACT_PUSH     8'd14
`define HEAP_ACT_POP      8'd15
`define HEAP_ACT_ALLOC    8'd18
`define HEAP_ACT_FREE     8'd19
`define HEAP_ACT_ADD      8'd20                        // Returns new value
`define HEAP_ACT_ADDAFTER 8'd21                        // Returns old value

// ------------------------------
// Error bases and offsets
`define HEAP_ERR_WRITE    32'd10000010
`define HEAP_ERR_READ     32'd10000020
`define HEAP_ERR_SIZE     32'd10000030
`define HEAP_ERR_PUSH     32'd10000120
`define HEAP_ERR_POP      32'd10000130
`define HEAP_ERR_FREE     32'd10000150
`define HEAP_ERR_ADD      32'd10000160
`define HEAP_ERR_ADDAFTER 32'd10000170
`define HEAP_ERR_NOT_LIVE 32'd1                        // Array not allocated
`define HEAP_ERR_BOUNDS   32'd2                        // Index at or past size
`define HEAP_ERR_LIMIT    32'd4                        // Full or empty
`define HEAP_ERR_OUT_OF_MEMORY 32'd10000270
`define HEAP_ERR_BAD_ACTION    32'd10000280

`endif

//--- logic/responseRegister.sv
// Response register
// Picks the allocator or store response, registers out and error, pulses done
`timescale 1ns/1ps
`include "heap_params.svh"

module responseRegister (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cmdValid,
  input  heapPkg::heapAction_t  cmdAction,             // Decides if out loads
  input  logic                  cmdBadAction,
  input  logic                  allocHit,
  input  heapPkg::element_t     allocResult,
  input  heapPkg::errorCode_t   allocError,
  input  heapPkg::element_t     storeResult,
  input  heapPkg::errorCode_t   storeError,
  output heapPkg::element_t     out,
  output heapPkg::errorCode_t   error,
  output logic                  done
);
  import heapPkg::*;

  element_t   selResult;
  errorCode_t selError;
  logic       setsOut;                                 // Command returns a value

  always_comb begin
    selResult = allocHit ? allocResult : storeResult;
    if (cmdBadAction) selError = `HEAP_ERR_BAD_ACTION;
    else if (allocHit) selError = allocError;
    else selError = storeError;
    case (cmdAction)
      actAlloc, actWrite, actRead, actSize, actPop, actAdd, actAddAfter: setsOut = 1'b1;
      default: setsOut = 1'b0;                         // Free, Reset, Push
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= '0;
      done  <= 1'b0;
    end else begin
      done <= cmdValid;
      if (cmdValid) error <= selError;
      if (cmdValid && setsOut && (selError == '0)) out <= selResult;  // Else hold
    end
  end

  doneSpacing: assert property (@(posedge clock) disable iff (reset)
    done ##1 done |-> $past(cmdValid, 1) && $past(cmdValid, 2));

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the heap testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module heapMemoryTb -f src.f -o heapMemorySim

# The simulator status is not trusted here, the log decides
./obj_dir/heapMemorySim 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

//--- src.f
+incdir+logic
logic/heapPkg.sv
logic/commandDecoder.sv
logic/arrayAllocator.sv
logic/arrayStore.sv
logic/responseRegister.sv
logic/heapMemory.sv
test/heapMemoryTb.sv

//--- test/heapMemoryTb.sv
// Heap memory testbench
// Runs allocation, element, stack, add and error commands through the heap and
// checks each response against a reference model of the heap rules
`timescale 1ns/1ps
`include "heap_params.svh"

module heapMemoryTb;
  import heapPkg::*;

  localparam int CLOCK_PERIOD  = 40;
  localparam int RESET_CYCLES  = 10;
  localparam int COMMAND_LIMIT = 120;                  // Upper bound on commands issued

  logic                         clock;
  logic                         reset;
  logic [`HEAP_ACTION_BITS-1:0] action;
  arrayId_t                     array;
  elementIndex_t                index;
  element_t                     data;
  element_t                     out;
  errorCode_t                   error;
  logic                         done;

  // ------------------------------
  // Reference model state
  bit         live [`HEAP_ARRAYS];
  int         freeList [$];                            // Latest freed at the back
  int         handedOut;                               // New arrays given so far
  int         sizes [`HEAP_ARRAYS];
  element_t   mem [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  element_t   lastOut;                                 // Value out should hold
  element_t   expOut [$];
  errorCode_t expErr [$];
  element_t   wantOut;
  errorCode_t wantErr;
  logic [15:0] lfsr;
  bit          spaced;                                 // Idle cycle after each command
  int          issued;

  heapMemory i_dut (
    .clock(clock), .reset(reset),
    .action(action), .array(array), .index(index), .data(data),
    .out(out), .error(error), .done(done)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] randomBits(input int width);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < width; i++) begin
      feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr     = {lfsr[14:0], feedback};
      value    = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic errorCode_t errorBase(input logic [7:0] act);
    case (act)
      `HEAP_ACT_WRITE:    return `HEAP_ERR_WRITE;
      `HEAP_ACT_READ:     return `HEAP_ERR_READ;
      `HEAP_ACT_SIZE:     return `HEAP_ERR_SIZE;
      `HEAP_ACT_PUSH:     return `HEAP_ERR_PUSH;
      `HEAP_ACT_POP:      return `HEAP_ERR_POP;
      `HEAP_ACT_FREE:     return `HEAP_ERR_FREE;
      `HEAP_ACT_ADD:      return `HEAP_ERR_ADD;
      `HEAP_ACT_ADDAFTER: return `HEAP_ERR_ADDAFTER;
      default:            return '0;                   // Reset, Alloc or unknown
    endcase
  endfunction

  // Element commands on a live array
  function automatic errorCode_t elementCommand(input logic [7:0] act, input int arr,
                                                input int idx, input element_t dat,
                                                input errorCode_t base);
    errorCode_t err;
    err = '0;
    case (act)
      `HEAP_ACT_WRITE: begin
        mem[arr][idx] = dat;
        if (sizes[arr] <= idx) sizes[arr] = idx + 1;   // Grows to cover index
        lastOut = dat;
      end
      `HEAP_ACT_SIZE: lastOut = element_t'(sizes[arr]);
      `HEAP_ACT_PUSH: begin
        if (sizes[arr] == `HEAP_ARRAY_LENGTH) err = base + `HEAP_ERR_LIMIT;
        else begin
          mem[arr][sizes[arr]] = dat;
          sizes[arr]++;
        end
      end
      `HEAP_ACT_POP: begin
        if (sizes[arr] == 0) err = base + `HEAP_ERR_LIMIT;
        else begin
          sizes[arr]--;
          lastOut = mem[arr][sizes[arr]];
        end
      end
      default: begin                                   // Read, Add, AddAfter
        if (idx >= sizes[arr]) err = base + `HEAP_ERR_BOUNDS;
        else if (act == `HEAP_ACT_READ) lastOut = mem[arr][idx];
        else if (act == `HEAP_ACT_ADD) begin
          mem[arr][idx] = mem[arr][idx] + dat;         // Wraps at 12 bits
          lastOut       = mem[arr][idx];
        end else begin
          lastOut       = mem[arr][idx];               // Old value returned
          mem[arr][idx] = mem[arr][idx] + dat;
        end
      end
    endcase
    return err;
  endfunction

  function automatic void modelCommand(input logic [7:0] act, input int arr, input int idx,
                                       input element_t dat);
    errorCode_t err;
    errorCode_t base;
    int         slot;
    err  = '0;
    base = errorBase(act);
    case (act)
      `HEAP_ACT_RESET: begin
        foreach (live[i]) live[i] = 1'b0;
        foreach (sizes[i]) sizes[i] = 0;
        freeList.delete();
        handedOut = 0;
      end
      `HEAP_ACT_ALLOC: begin
        slot = -1;
        if (freeList.size() != 0) slot = freeList.pop_back();
        else if (handedOut < `HEAP_ARRAYS - 1) begin
          slot = handedOut;
          handedOut++;
        end
        if (slot < 0) err = `HEAP_ERR_OUT_OF_MEMORY;
        else begin
          live[slot]  = 1'b1;
          sizes[slot] = 0;                             // Fresh array is empty
          lastOut     = element_t'(slot);
        end
      end
      `HEAP_ACT_FREE: begin
        if (!live[arr]) err = base + `HEAP_ERR_NOT_LIVE;
        else begin
          live[arr] = 1'b0;
          freeList.push_back(arr);
        end
      end
      default: begin
        if (base == '0) err = `HEAP_ERR_BAD_ACTION;
        else if (!live[arr]) err = base + `HEAP_ERR_NOT_LIVE;
        else err = elementCommand(act, arr, idx, dat, base);
      end
    endcase
    expOut.push_back(lastOut);
    expErr.push_back(err);
  endfunction

  task automatic issue(input logic [7:0] act, input int arr, input int idx, input element_t dat);
    @(posedge clock);
    commandBudget: assert (issued < COMMAND_LIMIT)
      else abortRun("more commands issued than the watchdog budget covers");
    action <= act;
    array  <= arrayId_t'(arr);
    index  <= elementIndex_t'(idx);
    data   <= dat;
    modelCommand(act, arr, idx, dat);
    issued++;
    if (spaced) begin
      @(posedge clock);
      action <= '0;
    end
  endtask

  task automatic settle();
    @(posedge clock);
    action <= '0;
    while (expErr.size() != 0) @(posedge clock);       // Drain pending responses
  endtask

  // ------------------------------
  // Command sequences
  task automatic allocOrder();
    repeat (4) issue(`HEAP_ACT_ALLOC, 0, 0, '0);       // Fourth runs out
    issue(`HEAP_ACT_FREE, 1, 0, '0);
    issue(`HEAP_ACT_FREE, 2, 0, '0);
    repeat (2) issue(`HEAP_ACT_ALLOC, 0, 0, '0);       // Expect 2 then 1
  endtask

  task automatic writeAndRead();
    bit wroteAt [4];
    int idx;
    for (int n = 0; n < 6; n++) begin
      idx          = int'(randomBits(2));              // Size stays at 4 or less
      wroteAt[idx] = 1'b1;
      issue(`HEAP_ACT_WRITE, 0, idx, element_t'(randomBits(`HEAP_DATA_BITS)));
    end
    for (int i = 0; i < 4; i++)
      if (wroteAt[i]) issue(`HEAP_ACT_READ, 0, i, '0);
    issue(`HEAP_ACT_SIZE, 0, 0, '0);
    issue(`HEAP_ACT_READ, 0, sizes[0], '0);            // First index past the end
    issue(`HEAP_ACT_READ, 0, `HEAP_ARRAY_LENGTH - 1, '0);
  endtask

  task automatic stackFillDrain();
    for (int n = 0; n < `HEAP_ARRAY_LENGTH; n++)
      issue(`HEAP_ACT_PUSH, 1, 0, element_t'(randomBits(`HEAP_DATA_BITS)));
    issue(`HEAP_ACT_PUSH, 1, 0, 12'h5a5);              // Array is full
    issue(`HEAP_ACT_SIZE, 1, 0, '0);
    for (int n = 0; n <= `HEAP_ARRAY_LENGTH; n++)      // Last pop finds it empty
      issue(`HEAP_ACT_POP, 1, 0, '0);
  endtask

  task automatic addCommands();
    issue(`HEAP_ACT_WRITE, 2, 0, element_t'(randomBits(`HEAP_DATA_BITS)));
    issue(`HEAP_ACT_WRITE, 2, 1, element_t'(randomBits(`HEAP_DATA_BITS)));
    issue(`HEAP_ACT_ADD, 2, 0, element_t'(randomBits(`HEAP_DATA_BITS)));
    issue(`HEAP_ACT_ADDAFTER, 2, 1, element_t'(randomBits(`HEAP_DATA_BITS)));
    issue(`HEAP_ACT_READ, 2, 1, '0);                   // Stored sum
    issue(`HEAP_ACT_READ, 2, 0, '0);
    issue(`HEAP_ACT_ADD, 2, 5, 12'h001);               // Past the size
    issue(`HEAP_ACT_ADDAFTER, 2, 2, 12'h001);
  endtask

  task automatic errorCases();
    issue(`HEAP_ACT_FREE, 2, 0, '0);
    issue(`HEAP_ACT_WRITE, 2, 0, 12'h0aa);
    issue(`HEAP_ACT_READ, 2, 0, '0);
    issue(`HEAP_ACT_SIZE, 2, 0, '0);
    issue(`HEAP_ACT_PUSH, 2, 0, 12'h0bb);
    issue(`HEAP_ACT_POP, 2, 0, '0);
    issue(`HEAP_ACT_ADD, 2, 0, 12'h001);
    issue(`HEAP_ACT_ADDAFTER, 2, 0, 12'h001);
    issue(`HEAP_ACT_FREE, 2, 0, '0);                   // Second free
    issue(8'd5, 0, 0, '0);                             // Codes outside the kept set
    issue(8'd99, 0, 0, '0);
    issue(`HEAP_ACT_RESET, 0, 0, '0);
    issue(`HEAP_ACT_READ, 0, 0, '0);
    issue(`HEAP_ACT_SIZE, 1, 0, '0);
    issue(`HEAP_ACT_FREE, 0, 0, '0);
    issue(`HEAP_ACT_ALLOC, 0, 0, '0);                  // Count starts over
  endtask

  task automatic mixedBurst();
    issue(`HEAP_ACT_RESET, 0, 0, '0);
    issue(`HEAP_ACT_ALLOC, 0, 0, '0);
    issue(`HEAP_ACT_ALLOC, 0, 0, '0);
    issue(`HEAP_ACT_WRITE, 0, 2, 12'h7ff);
    issue(`HEAP_ACT_PUSH, 1, 0, 12'h123);
    issue(`HEAP_ACT_PUSH, 1, 0, 12'hfff);
    issue(`HEAP_ACT_ADD, 0, 2, 12'h801);               // Sum wraps to zero
    issue(`HEAP_ACT_POP, 1, 0, '0);
    issue(`HEAP_ACT_ADDAFTER, 1, 0, 12'h001);
    issue(`HEAP_ACT_READ, 1, 0, '0);
    issue(`HEAP_ACT_SIZE, 0, 0, '0);
    issue(8'd200, 0, 0, '0);
    issue(`HEAP_ACT_WRITE, 3, 0, 12'h001);             // Never allocated
    issue(`HEAP_ACT_FREE, 0, 0, '0);
    issue(`HEAP_ACT_READ, 0, 2, '0);
    issue(`HEAP_ACT_ALLOC, 0, 0, '0);
    issue(`HEAP_ACT_SIZE, 0, 0, '0);
  endtask

  // ------------------------------
  // Response checks
  doneAfterCommand: assert property (@(posedge clock) disable iff (reset)
    (action != '0) |-> ##2 done)
    else abortRun($sformatf("done missing two cycles after a command, at %0t", $time));

  noStrayDone: assert property (@(posedge clock) disable iff (reset)
    done |-> ($past(action, 2) != '0))
    else abortRun($sformatf("done at %0t without a command two cycles before", $time));

  always @(negedge clock) begin                        // Outputs settled mid cycle
    if (!reset && done) begin
      if (expErr.size() == 0) abortRun("done raised with no command pending");
      else begin
        wantErr = expErr.pop_front();
        wantOut = expOut.pop_front();
        errorCheck: assert (error == wantErr)
          else abortRun($sformatf("mismatch at %0t: error expected %0d, got %0d",
                                  $time, wantErr, error));
        outCheck: assert (out == wantOut)
          else abortRun($sformatf("mismatch at %0t: out expected 0x%03h, got 0x%03h",
                                  $time, wantOut, out));
      end
    end
  end

  initial begin : watchdog
    #(CLOCK_PERIOD * (4 * COMMAND_LIMIT + RESET_CYCLES));
    abortRun("watchdog expired before all responses arrived");
  end

  // ------------------------------
  // Main sequence
  initial begin
    clock     = 1'b0;
    reset     = 1'b1;
    action    = '0;
    array     = '0;
    index     = '0;
    data      = '0;
    lfsr      = 16'd53;
    spaced    = 1'b1;
    issued    = 0;
    handedOut = 0;
    lastOut   = '0;                                    // out is 0 after reset
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    allocOrder();
    writeAndRead();
    stackFillDrain();
    addCommands();
    errorCases();
    mixedBurst();
    settle();
    spaced = 1'b0;                                     // Same burst with no gaps
    mixedBurst();
    settle();
    $display("TB PASSED");
    $finish;
  end

endmodule
